// ==== src/fp_mul_pkg.sv ====
// binary32 format constants and stage record types for the pipelined multiply front end
package fp_mul_pkg;

    //////////////////////////////////////////////////
    // binary32 format
    localparam int FLEN       = 32;
    localparam int EXPO_WIDTH = 8;
    localparam int FRAC_WIDTH = 23;
    localparam int EXPO_BIAS  = 127;
    localparam int GRS_WIDTH  = 3;

    typedef logic [FLEN-1:0] fp_word_t;
    typedef logic [2:0]      rm_t;

    // default quiet NaN
    localparam fp_word_t CANONICAL_NAN = 32'h7FC0_0000;

    // frac carries the hidden bit on top
    typedef struct packed {
        logic                  sign;
        logic [EXPO_WIDTH-1:0] expo;
        logic [FRAC_WIDTH:0]   frac;
    } operand_t;

    typedef struct packed {
        logic zero;
        logic subnormal;
        logic inf;
        logic qnan;
        logic snan;
    } operand_class_t;

    typedef struct packed {
        logic invalid;
        logic nan;
        logic inf;
        logic zero;
    } mul_flags_t;

    //////////////////////////////////////////////////
    // stage records
    typedef struct packed {
        operand_t   rs1;
        operand_t   rs2;
        mul_flags_t flags;
        rm_t        rm;
    } classify_payload_t;

    typedef struct packed {
        logic                  rs1_sign;
        logic                  rs2_sign;
        logic [EXPO_WIDTH-1:0] rs1_expo;
        logic [EXPO_WIDTH-1:0] rs2_expo;
        mul_flags_t            flags;
        rm_t                   rm;
    } product_payload_t;

    // unrounded record for the rounding unit
    typedef struct packed {
        fp_word_t             rd;
        logic                 safe;
        logic                 hidden;
        logic [GRS_WIDTH-1:0] grs;
        logic                 expo_overflow;
        logic                 underflow;
        logic                 invalid;
        rm_t                  rm;
    } result_payload_t;

    // subnormals flush to zero, so a zero exponent means no hidden bit and no fraction
    function automatic operand_t unpack_operand(input fp_word_t word);
        operand_t op;
        op.sign = word[FLEN-1];
        op.expo = word[FLEN-2 -: EXPO_WIDTH];
        if (op.expo == '0) begin
            op.frac = '0;
        end else begin
            op.frac = {1'b1, word[FRAC_WIDTH-1:0]};
        end
        return op;
    endfunction

endpackage

// ==== src/fp_stage_if.sv ====
// one pipeline hop between two stages with valid, id, payload and a backward advance
`timescale 1ns/1ps

interface fp_stage_if #(
    parameter int  ID_WIDTH  = 4,
    parameter type payload_t = logic
) ();

    // held by the producer until advance is seen at a clock edge
    logic                valid;
    logic [ID_WIDTH-1:0] id;
    payload_t            payload;

    // from the consumer: the producer register may load this cycle
    logic                advance;

    modport producer (
        output valid,
        output id,
        output payload,
        input  advance
    );

    modport consumer (
        input  valid,
        input  id,
        input  payload,
        output advance
    );

endinterface

// ==== src/fp_stage_reg.sv ====
// pipeline stage register holding one item, loaded whenever the downstream hop advances
`timescale 1ns/1ps

module fp_stage_reg #(
    parameter int  ID_WIDTH  = 4,
    parameter type payload_t = fp_mul_pkg::classify_payload_t
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic [ID_WIDTH-1:0] in_id,
    input  payload_t            in_payload,
    fp_stage_if.producer        downstream
);

    logic                valid_q;
    logic [ID_WIDTH-1:0] id_q;
    payload_t            payload_q;

    // a bubble loads as well, which empties the stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (downstream.advance) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (downstream.advance) begin
            id_q      <= in_id;
            payload_q <= in_payload;
        end
    end

    assign downstream.valid   = valid_q;
    assign downstream.id      = id_q;
    assign downstream.payload = payload_q;

endmodule

// ==== src/fp_operand_classify.sv ====
// classify stage: decodes both operands and forms the special-case flags of the product
`timescale 1ns/1ps

module fp_operand_classify #(
    parameter int ID_WIDTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [ID_WIDTH-1:0]  in_id,
    input  fp_mul_pkg::fp_word_t rs1,
    input  fp_mul_pkg::fp_word_t rs2,
    input  fp_mul_pkg::rm_t      rm,
    fp_stage_if.producer         out
);

    localparam int EXPO_WIDTH = fp_mul_pkg::EXPO_WIDTH;
    localparam int FRAC_WIDTH = fp_mul_pkg::FRAC_WIDTH;

    fp_mul_pkg::operand_class_t    rs1_cls;
    fp_mul_pkg::operand_class_t    rs2_cls;
    logic                          rs1_zero;
    logic                          rs2_zero;
    logic                          rs1_nan;
    logic                          rs2_nan;
    fp_mul_pkg::mul_flags_t        flags;
    fp_mul_pkg::classify_payload_t cls_payload;

    // field decode, quiet bit is the top fraction bit
    function automatic fp_mul_pkg::operand_class_t decode_class(
        input fp_mul_pkg::fp_word_t word
    );
        fp_mul_pkg::operand_class_t cls;
        logic expo_zero;
        logic expo_ones;
        logic frac_zero;
        expo_zero     = ~|word[fp_mul_pkg::FLEN-2 -: EXPO_WIDTH];
        expo_ones     = &word[fp_mul_pkg::FLEN-2 -: EXPO_WIDTH];
        frac_zero     = ~|word[FRAC_WIDTH-1:0];
        cls.zero      = expo_zero & frac_zero;
        cls.subnormal = expo_zero & ~frac_zero;
        cls.inf       = expo_ones & frac_zero;
        cls.qnan      = expo_ones & word[FRAC_WIDTH-1];
        cls.snan      = expo_ones & ~frac_zero & ~word[FRAC_WIDTH-1];
        return cls;
    endfunction

    assign rs1_cls = decode_class(rs1);
    assign rs2_cls = decode_class(rs2);

    // subnormal operands count as zero
    assign rs1_zero = rs1_cls.zero | rs1_cls.subnormal;
    assign rs2_zero = rs2_cls.zero | rs2_cls.subnormal;
    assign rs1_nan  = rs1_cls.qnan | rs1_cls.snan;
    assign rs2_nan  = rs2_cls.qnan | rs2_cls.snan;

    //////////////////////////////////////////////////
    // special-case flags
    assign flags.invalid = (rs1_zero & rs2_cls.inf) | (rs1_cls.inf & rs2_zero)
                         | rs1_cls.snan | rs2_cls.snan;
    assign flags.nan     = flags.invalid | rs1_nan | rs2_nan;
    assign flags.inf     = ((rs1_cls.inf & ~rs2_zero) | (~rs1_zero & rs2_cls.inf)) & ~flags.nan;
    assign flags.zero    = (rs1_zero | rs2_zero) & ~flags.nan;

    assign cls_payload.rs1   = fp_mul_pkg::unpack_operand(rs1);
    assign cls_payload.rs2   = fp_mul_pkg::unpack_operand(rs2);
    assign cls_payload.flags = flags;
    assign cls_payload.rm    = rm;

    fp_stage_reg #(
        .ID_WIDTH  (ID_WIDTH),
        .payload_t (fp_mul_pkg::classify_payload_t)
    ) cls_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_id      (in_id),
        .in_payload (cls_payload),
        .downstream (out)
    );

    assign in_ready = out.advance;

endmodule

// ==== src/fp_mantissa_mul.sv ====
// two-stage unsigned mantissa multiplier stepped by the pipeline advance strobes
`timescale 1ns/1ps

module fp_mantissa_mul #(
    parameter int WIDTH = fp_mul_pkg::FRAC_WIDTH + 1
) (
    input  logic               clk,
    input  logic               advance1,
    input  logic               advance2,
    input  logic [WIDTH-1:0]   a,
    input  logic [WIDTH-1:0]   b,
    output logic [2*WIDTH-1:0] product
);

    logic [WIDTH-1:0]   a_q;
    logic [WIDTH-1:0]   b_q;
    logic [2*WIDTH-1:0] product_d;
    logic [2*WIDTH-1:0] product_q;

    //////////////////////////////////////////////////
    // operand stage
    // loads together with the classify register
    always_ff @(posedge clk) begin
        if (advance1) begin
            a_q <= a;
            b_q <= b;
        end
    end

    //////////////////////////////////////////////////
    // product stage
    assign product_d = a_q * b_q;

    // loads together with the multiply stage register,
    // so the product follows its item through a stall
    always_ff @(posedge clk) begin
        if (advance2) begin
            product_q <= product_d;
        end
    end

    assign product = product_q;

endmodule

// ==== src/fp_product_assemble.sv ====
// assemble stage: sign, exponent, guard/round/sticky and special results into the output record
`timescale 1ns/1ps

module fp_product_assemble #(
    parameter int ID_WIDTH = 4
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    fp_stage_if.consumer                             in,
    input  logic [2*(fp_mul_pkg::FRAC_WIDTH+1)-1:0] product,
    output logic                                     out_valid,
    input  logic                                     out_ack,
    output logic [ID_WIDTH-1:0]                      out_id,
    output fp_mul_pkg::result_payload_t              out_result
);

    localparam int EXPO_WIDTH = fp_mul_pkg::EXPO_WIDTH;
    localparam int FRAC_WIDTH = fp_mul_pkg::FRAC_WIDTH;
    localparam int GRS_WIDTH  = fp_mul_pkg::GRS_WIDTH;

    fp_mul_pkg::mul_flags_t      flags;
    logic                        res_sign;
    logic [EXPO_WIDTH+1:0]       expo_sum;
    logic [EXPO_WIDTH:0]         res_expo;
    logic                        underflow;
    logic                        special;
    logic [FRAC_WIDTH+1:0]       res_mant;
    logic [FRAC_WIDTH-1:0]       residual;
    logic [GRS_WIDTH-1:0]        grs;
    fp_mul_pkg::fp_word_t        special_word;
    fp_mul_pkg::result_payload_t result_d;
    logic                        advance;

    assign flags    = in.payload.flags;
    assign res_sign = in.payload.rs1_sign ^ in.payload.rs2_sign;

    //////////////////////////////////////////////////
    // exponent
    // sign bit on top of the 9-bit result exponent
    assign expo_sum = {2'b00, in.payload.rs1_expo} + {2'b00, in.payload.rs2_expo}
                    - (EXPO_WIDTH+2)'(fp_mul_pkg::EXPO_BIAS);
    assign underflow = expo_sum[EXPO_WIDTH+1];
    assign res_expo  = expo_sum[EXPO_WIDTH:0] & {(EXPO_WIDTH+1){~flags.zero}};

    //////////////////////////////////////////////////
    // mantissa
    // {safe, hidden, fraction} from the top of the product
    assign res_mant = product[2*FRAC_WIDTH+1 -: FRAC_WIDTH+2];
    assign residual = product[FRAC_WIDTH-1:0];
    assign grs      = {residual[FRAC_WIDTH-1 -: GRS_WIDTH-1],
                       |residual[FRAC_WIDTH-GRS_WIDTH:0]};

    // special results
    assign special = flags.inf | flags.nan | flags.zero;

    always_comb begin
        if (flags.inf) begin
            special_word = {res_sign, {EXPO_WIDTH{1'b1}}, {FRAC_WIDTH{1'b0}}};
        end else if (flags.nan) begin
            special_word = fp_mul_pkg::CANONICAL_NAN;
        end else begin
            special_word = {res_sign, {(fp_mul_pkg::FLEN-1){1'b0}}};
        end
    end

    always_comb begin
        result_d.rd            = special ? special_word
                               : {res_sign, res_expo[EXPO_WIDTH-1:0], res_mant[FRAC_WIDTH-1:0]};
        result_d.safe          = res_mant[FRAC_WIDTH+1];
        result_d.hidden        = res_mant[FRAC_WIDTH];
        result_d.grs           = special ? '0 : grs;
        // a negative sum also sets bit 8, which is not an overflow
        result_d.expo_overflow = res_expo[EXPO_WIDTH] & ~underflow & ~special;
        result_d.underflow     = underflow & ~special;
        result_d.invalid       = flags.invalid;
        result_d.rm            = in.payload.rm;
    end

    //////////////////////////////////////////////////
    // output register and advance chain end
    assign advance    = ~out_valid | out_ack;
    assign in.advance = ~in.valid | advance;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_id     <= in.id;
            out_result <= result_d;
        end
    end

endmodule

// ==== src/fp_mul_top.sv ====
// single-precision multiply front end: classify, multiply and assemble stages with stall chain
`timescale 1ns/1ps

module fp_mul_top #(
    parameter int ID_WIDTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // request side
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [ID_WIDTH-1:0]    in_id,
    input  fp_mul_pkg::fp_word_t   rs1,
    input  fp_mul_pkg::fp_word_t   rs2,
    input  fp_mul_pkg::rm_t        rm,
    // result side
    output logic                   out_valid,
    input  logic                   out_ack,
    output logic [ID_WIDTH-1:0]    out_id,
    output fp_mul_pkg::fp_word_t   out_rd,
    output logic                   out_safe,
    output logic                   out_hidden,
    output logic [2:0]             out_grs,
    output logic                   out_expo_overflow,
    output logic                   out_underflow,
    output logic                   out_invalid,
    output fp_mul_pkg::rm_t        out_rm
);

    fp_mul_pkg::operand_t         rs1_op;
    fp_mul_pkg::operand_t         rs2_op;
    fp_mul_pkg::product_payload_t mul_payload;
    fp_mul_pkg::result_payload_t  result;
    logic [2*(fp_mul_pkg::FRAC_WIDTH+1)-1:0] product;

    fp_stage_if #(.ID_WIDTH(ID_WIDTH), .payload_t(fp_mul_pkg::classify_payload_t)) cls_to_mul ();
    fp_stage_if #(.ID_WIDTH(ID_WIDTH), .payload_t(fp_mul_pkg::product_payload_t))  mul_to_asm ();

    //////////////////////////////////////////////////
    // classify stage
    fp_operand_classify #(.ID_WIDTH(ID_WIDTH)) classify (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_id    (in_id),
        .rs1      (rs1),
        .rs2      (rs2),
        .rm       (rm),
        .out      (cls_to_mul)
    );

    // multiply stage is the consumer of the classify hop
    assign cls_to_mul.advance = ~cls_to_mul.valid | mul_to_asm.advance;

    // multiplier operands enter alongside the classify register
    assign rs1_op = fp_mul_pkg::unpack_operand(rs1);
    assign rs2_op = fp_mul_pkg::unpack_operand(rs2);

    fp_mantissa_mul #(.WIDTH(fp_mul_pkg::FRAC_WIDTH + 1)) mantissa_mul (
        .clk      (clk),
        .advance1 (cls_to_mul.advance),
        .advance2 (mul_to_asm.advance),
        .a        (rs1_op.frac),
        .b        (rs2_op.frac),
        .product  (product)
    );

    //////////////////////////////////////////////////
    // multiply stage
    assign mul_payload.rs1_sign = cls_to_mul.payload.rs1.sign;
    assign mul_payload.rs2_sign = cls_to_mul.payload.rs2.sign;
    assign mul_payload.rs1_expo = cls_to_mul.payload.rs1.expo;
    assign mul_payload.rs2_expo = cls_to_mul.payload.rs2.expo;
    assign mul_payload.flags    = cls_to_mul.payload.flags;
    assign mul_payload.rm       = cls_to_mul.payload.rm;

    fp_stage_reg #(.ID_WIDTH(ID_WIDTH), .payload_t(fp_mul_pkg::product_payload_t)) mul_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (cls_to_mul.valid),
        .in_id      (cls_to_mul.id),
        .in_payload (mul_payload),
        .downstream (mul_to_asm)
    );

    //////////////////////////////////////////////////
    // assemble stage
    fp_product_assemble #(.ID_WIDTH(ID_WIDTH)) assemble (
        .clk        (clk),
        .rst_n      (rst_n),
        .in         (mul_to_asm),
        .product    (product),
        .out_valid  (out_valid),
        .out_ack    (out_ack),
        .out_id     (out_id),
        .out_result (result)
    );

    assign out_rd            = result.rd;
    assign out_safe          = result.safe;
    assign out_hidden        = result.hidden;
    assign out_grs           = result.grs;
    assign out_expo_overflow = result.expo_overflow;
    assign out_underflow     = result.underflow;
    assign out_invalid       = result.invalid;
    assign out_rm            = result.rm;

endmodule

// ==== verif/fp_mul_tb_checks.svh ====
// drive, wait and compare tasks for the multiply front end testbench

//////////////////////////////////////////////////
// failure reporting
task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first failure");
endtask

task automatic fail_run(input string reason);
    $display("Failure at time %0t: %s", $time, reason);
    stop_with_failure();
endtask

//////////////////////////////////////////////////
// compares, one per kind of result
task automatic compare_word(input string name, input fp_mul_pkg::fp_word_t expected,
                            input fp_mul_pkg::fp_word_t actual);
    if (actual !== expected) begin
        $display("** Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        stop_with_failure();
    end
endtask

task automatic compare_rm(input string name, input fp_mul_pkg::rm_t expected,
                          input fp_mul_pkg::rm_t actual);
    if (actual !== expected) begin
        $display("** Error at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        stop_with_failure();
    end
endtask

task automatic compare_grs(input string name, input logic [2:0] expected,
                           input logic [2:0] actual);
    if (actual !== expected) begin
        $display("** Error at time %0t: %s expected %b, got %b", $time, name, expected, actual);
        stop_with_failure();
    end
endtask

task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("** Error at time %0t: %s expected %b, got %b", $time, name, expected, actual);
        stop_with_failure();
    end
endtask

task automatic compare_id(input string name, input logic [ID_WIDTH-1:0] expected,
                          input logic [ID_WIDTH-1:0] actual);
    if (actual !== expected) begin
        $display("** Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        stop_with_failure();
    end
endtask

//////////////////////////////////////////////////
// request side
task automatic queue_pair(input fp_mul_pkg::fp_word_t a, input fp_mul_pkg::fp_word_t b);
    stim_a_q.push_back(a);
    stim_b_q.push_back(b);
endtask

// offers one request for one edge, called 1 ns after a rising edge
task automatic try_request(input fp_mul_pkg::fp_word_t a, input fp_mul_pkg::fp_word_t b,
                           input fp_mul_pkg::rm_t mode, output logic taken);
    in_valid = 1'b1;
    in_id    = next_id;
    rs1      = a;
    rs2      = b;
    rm       = mode;
    @(posedge clk);
    taken = in_ready;
    #1;
    if (taken) begin
        expected_q.push_back(expected_result(a, b, mode));
        expected_id_q.push_back(next_id);
        next_id = next_id + 1'b1;
    end
endtask

task automatic send_request(input fp_mul_pkg::fp_word_t a, input fp_mul_pkg::fp_word_t b,
                            input fp_mul_pkg::rm_t mode);
    logic taken;
    int   waited;
    taken  = 1'b0;
    waited = 0;
    while (!taken) begin
        if (waited == TIMEOUT) begin
            fail_run("request was not accepted before the timeout");
        end
        try_request(a, b, mode, taken);
        waited++;
    end
endtask

//////////////////////////////////////////////////
// result side
task automatic check_result();
    fp_mul_pkg::result_payload_t exp;
    logic [ID_WIDTH-1:0]         exp_id;
    if (expected_q.size() == 0) begin
        fail_run("a result arrived with no request outstanding");
    end
    exp    = expected_q.pop_front();
    exp_id = expected_id_q.pop_front();
    compare_id("out_id", exp_id, out_id);
    compare_word("out_rd", exp.rd, out_rd);
    compare_flag("out_safe", exp.safe, out_safe);
    compare_flag("out_hidden", exp.hidden, out_hidden);
    compare_grs("out_grs", exp.grs, out_grs);
    compare_flag("out_expo_overflow", exp.expo_overflow, out_expo_overflow);
    compare_flag("out_underflow", exp.underflow, out_underflow);
    compare_flag("out_invalid", exp.invalid, out_invalid);
    compare_rm("out_rm", exp.rm, out_rm);
endtask

// outputs are read at the rising edge, before the registers update
task automatic collect_results(input int count);
    int waited;
    repeat (count) begin
        waited = 0;
        @(posedge clk);
        while (!(out_valid && out_ack)) begin
            if (waited == TIMEOUT) begin
                fail_run("expected result did not arrive before the timeout");
            end
            waited++;
            @(posedge clk);
        end
        check_result();
        // back off the edge before anything is driven again
        #1;
    end
endtask

// ==== verif/fp_mul_tb.sv ====
// testbench for the pipelined binary32 multiply front end with a behavioral model
`timescale 1ns/1ps

module fp_mul_tb;

    localparam int ID_WIDTH = 4;
    localparam int TIMEOUT  = 100;

    logic                        clk;
    logic                        rst_n;
    logic                        in_valid;
    logic                        in_ready;
    logic [ID_WIDTH-1:0]         in_id;
    fp_mul_pkg::fp_word_t        rs1;
    fp_mul_pkg::fp_word_t        rs2;
    fp_mul_pkg::rm_t             rm;
    logic                        out_valid;
    logic                        out_ack;
    logic [ID_WIDTH-1:0]         out_id;
    fp_mul_pkg::fp_word_t        out_rd;
    logic                        out_safe;
    logic                        out_hidden;
    logic [2:0]                  out_grs;
    logic                        out_expo_overflow;
    logic                        out_underflow;
    logic                        out_invalid;
    fp_mul_pkg::rm_t             out_rm;

    integer                      seed;
    logic [ID_WIDTH-1:0]         next_id;
    fp_mul_pkg::fp_word_t        stim_a_q[$];
    fp_mul_pkg::fp_word_t        stim_b_q[$];
    fp_mul_pkg::result_payload_t expected_q[$];
    logic [ID_WIDTH-1:0]         expected_id_q[$];

    //////////////////////////////////////////////////
    // behavioral model of the unrounded product record
    function automatic fp_mul_pkg::result_payload_t expected_result(
        input fp_mul_pkg::fp_word_t a,
        input fp_mul_pkg::fp_word_t b,
        input fp_mul_pkg::rm_t      mode
    );
        fp_mul_pkg::result_payload_t r;
        logic [7:0]  ea;
        logic [7:0]  eb;
        logic [23:0] ma;
        logic [23:0] mb;
        logic [47:0] prod;
        logic        za;
        logic        zb;
        logic        ia;
        logic        ib;
        logic        na;
        logic        nb;
        logic        sign;
        logic        any_nan;
        int          sum;
        ea = a[30:23];
        eb = b[30:23];
        // zero exponent covers true zeros and flushed subnormals
        za = (ea == 8'h00);
        zb = (eb == 8'h00);
        ia = (ea == 8'hFF) && (a[22:0] == 23'h0);
        ib = (eb == 8'hFF) && (b[22:0] == 23'h0);
        na = (ea == 8'hFF) && (a[22:0] != 23'h0);
        nb = (eb == 8'hFF) && (b[22:0] != 23'h0);
        ma = za ? 24'h0 : {1'b1, a[22:0]};
        mb = zb ? 24'h0 : {1'b1, b[22:0]};
        prod = {24'h0, ma} * {24'h0, mb};
        sum  = int'(ea) + int'(eb) - fp_mul_pkg::EXPO_BIAS;
        sign = a[31] ^ b[31];
        r.invalid = (za && ib) || (ia && zb) || (na && !a[22]) || (nb && !b[22]);
        any_nan   = r.invalid || na || nb;
        r.safe    = prod[47];
        r.hidden  = prod[46];
        r.rm      = mode;
        r.grs           = 3'b000;
        r.expo_overflow = 1'b0;
        r.underflow     = 1'b0;
        if (any_nan) begin
            r.rd = fp_mul_pkg::CANONICAL_NAN;
        end else if (ia || ib) begin
            r.rd = {sign, 8'hFF, 23'h0};
        end else if (za || zb) begin
            r.rd = {sign, 31'h0};
        end else begin
            r.rd            = {sign, sum[7:0], prod[45:23]};
            r.grs           = {prod[22:21], |prod[20:0]};
            r.expo_overflow = (sum > 255);
            r.underflow     = (sum < 0);
        end
        return r;
    endfunction

    // normal operand with its exponent in [lo, lo+span)
    function automatic fp_mul_pkg::fp_word_t random_normal(input int lo, input int span);
        fp_mul_pkg::fp_word_t word;
        logic [31:0]          pick;
        int                   expo;
        word = $random(seed);
        pick = $random(seed);
        expo = lo + int'(pick[15:0]) % span;
        word[30:23] = expo[7:0];
        return word;
    endfunction

    `include "fp_mul_tb_checks.svh"

    fp_mul_top #(.ID_WIDTH(ID_WIDTH)) fp_mul_top_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .in_valid          (in_valid),
        .in_ready          (in_ready),
        .in_id             (in_id),
        .rs1               (rs1),
        .rs2               (rs2),
        .rm                (rm),
        .out_valid         (out_valid),
        .out_ack           (out_ack),
        .out_id            (out_id),
        .out_rd            (out_rd),
        .out_safe          (out_safe),
        .out_hidden        (out_hidden),
        .out_grs           (out_grs),
        .out_expo_overflow (out_expo_overflow),
        .out_underflow     (out_underflow),
        .out_invalid       (out_invalid),
        .out_rm            (out_rm)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // tests
    // sends the queued pairs while collecting their results plus those still in flight
    task automatic stream_queued_pairs(input int pending);
        int count;
        count = stim_a_q.size() + pending;
        fork
            begin
                while (stim_a_q.size() > 0) begin
                    send_request(stim_a_q.pop_front(), stim_b_q.pop_front(),
                                 fp_mul_pkg::rm_t'($random(seed)));
                end
                in_valid = 1'b0;
            end
            collect_results(count);
        join
    endtask

    task automatic reset_state_test();
        @(posedge clk);
        compare_flag("out_valid", 1'b0, out_valid);
        compare_flag("in_ready", 1'b1, in_ready);
        #1;
    endtask

    task automatic normal_product_test();
        repeat (24) begin
            queue_pair(random_normal(64, 128), random_normal(64, 128));
        end
        stream_queued_pairs(0);
    endtask

    task automatic special_case_test();
        // NaN results, with and without invalid
        queue_pair(32'h0000_0000, 32'h7F80_0000);
        queue_pair(32'hFF80_0000, 32'h8000_0000);
        queue_pair(32'h7F80_0001, 32'h3F80_0000);
        queue_pair(32'h4040_0000, 32'hFFA0_0000);
        queue_pair(32'h7FC0_0000, 32'h4000_0000);
        queue_pair(32'h3F80_0000, 32'hFFC1_2345);
        queue_pair(32'h7FC0_0000, 32'h7F80_0001);
        // infinities
        queue_pair(32'hFF80_0000, 32'h4040_0000);
        queue_pair(32'h7F80_0000, 32'hFF80_0000);
        // zeros and flushed subnormals
        queue_pair(32'h8000_0000, 32'h3F80_0000);
        queue_pair(32'h0000_0001, 32'hC000_0000);
        queue_pair(32'h4120_0000, 32'h807F_FFFF);
        queue_pair(32'h0000_0000, 32'h0040_0000);
        stream_queued_pairs(0);
    endtask

    task automatic exponent_range_test();
        queue_pair(32'h7F00_0000, 32'h7F00_0000);
        queue_pair(32'h7F7F_FFFF, 32'h4000_0000);
        queue_pair(32'h7F7F_FFFF, 32'h4080_0000);
        queue_pair(32'h0080_0000, 32'h0080_0000);
        queue_pair(32'h0100_0000, 32'h3E80_0000);
        queue_pair(32'h0100_0000, 32'h3E00_0000);
        repeat (6) begin
            queue_pair(random_normal(200, 55), random_normal(200, 55));
            queue_pair(random_normal(1, 50), random_normal(1, 50));
        end
        stream_queued_pairs(0);
    endtask

    task automatic backpressure_test();
        int   accepted;
        logic taken;
        accepted = 0;
        taken    = 1'b1;
        out_ack  = 1'b0;
        while (taken) begin
            if (accepted > 8) begin
                fail_run("in_ready stayed high while out_ack was held low");
            end
            try_request(random_normal(64, 128), random_normal(64, 128),
                        fp_mul_pkg::rm_t'($random(seed)), taken);
            if (taken) begin
                accepted++;
            end
        end
        in_valid = 1'b0;
        if (accepted != 3) begin
            fail_run($sformatf("stalled pipeline accepted %0d requests instead of 3", accepted));
        end
        // full pipeline holds its output
        repeat (4) begin
            @(posedge clk);
            compare_flag("out_valid", 1'b1, out_valid);
            compare_flag("in_ready", 1'b0, in_ready);
            #1;
        end
        out_ack = 1'b1;
        repeat (5) begin
            queue_pair(random_normal(64, 128), random_normal(64, 128));
        end
        stream_queued_pairs(accepted);
        // nothing left to deliver
        repeat (4) begin
            @(posedge clk);
            compare_flag("out_valid", 1'b0, out_valid);
            #1;
        end
    endtask

    initial begin
        seed        = 32'h35ef_cdd9;
        next_id     = '0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_id       = '0;
        rs1         = '0;
        rs2         = '0;
        rm          = '0;
        out_ack     = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_state_test();
        normal_product_test();
        special_case_test();
        exponent_range_test();
        backpressure_test();
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+verif
src/fp_mul_pkg.sv
src/fp_stage_if.sv
src/fp_stage_reg.sv
src/fp_operand_classify.sv
src/fp_mantissa_mul.sv
src/fp_product_assemble.sv
src/fp_mul_top.sv
verif/fp_mul_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the multiply front end testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=fp_mul_sim

rm -rf "$BUILD_DIR"

verilator --binary --timing \
    -f verilog.f \
    --top-module fp_mul_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"

# the simulator status is not trusted alone, the log decides
"./$BUILD_DIR/$SIM_BIN" 2>&1 | tee "$LOG_FILE"

if grep -qx "Done: no errors" "$LOG_FILE"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG_FILE"
    exit 1
fi
